/* Makefile */
TOP := tb_execute_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* src/alu_branch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module alu_branch (
    input  exec_pkg::exec_fun_t fun,
    input  logic [`XLEN-1:0]    op1,
    input  logic [`XLEN-1:0]    op2,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    imm_b,
    output exec_pkg::alu_res_t  res
);
    import exec_pkg::*;

    logic [4:0]       shamt;
    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic [`XLEN-1:0] sum;

    assign shamt = op2[4:0];
    assign eq    = op1 == op2;
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;
    assign sum   = op1 + op2;

    always_comb begin
        res.alu_out   = '0;
        res.br_taken  = 1'b0;
        res.br_target = pc + imm_b;

        case (fun)
            ADD:   res.alu_out = sum;
            SUB:   res.alu_out = op1 - op2;
            AND:   res.alu_out = op1 & op2;
            OR:    res.alu_out = op1 | op2;
            XOR:   res.alu_out = op1 ^ op2;
            SLL:   res.alu_out = op1 << shamt;
            SRL:   res.alu_out = op1 >> shamt;
            SRA:   res.alu_out = $unsigned($signed(op1) >>> shamt);
            SLT:   res.alu_out = {{(`XLEN-1){1'b0}}, lt_s};
            SLTU:  res.alu_out = {{(`XLEN-1){1'b0}}, lt_u};
            // jump target with the low bit forced to zero
            JALR:  res.alu_out = {sum[`XLEN-1:1], 1'b0};
            COPY1: res.alu_out = op1;
            default: res.alu_out = '0;
        endcase

        case (fun)
            BEQ:     res.br_taken = eq;
            BNE:     res.br_taken = !eq;
            BLT:     res.br_taken = lt_s;
            BGE:     res.br_taken = !lt_s;
            BLTU:    res.br_taken = lt_u;
            BGEU:    res.br_taken = !lt_u;
            default: res.br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module div_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             is_signed,
    input  logic             abort,
    input  logic [`XLEN-1:0] dividend,
    input  logic [`XLEN-1:0] divisor,
    output logic             done,
    output logic [`XLEN-1:0] quotient,
    output logic [`XLEN-1:0] remainder
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    logic             running;
    logic [CNT_W-1:0] cnt;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] rem;
    logic [`XLEN-1:0] dvs;
    logic             neg_q;
    logic             neg_r;
    logic [`XLEN-1:0] dividend_mag;
    logic [`XLEN-1:0] divisor_mag;
    logic [`XLEN:0]   shifted;
    logic [`XLEN:0]   trial;

    // divide magnitudes and restore the signs at the end
    assign dividend_mag = (is_signed && dividend[`XLEN-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[`XLEN-1]) ? -divisor : divisor;

    // partial remainder shifted by one with the next dividend bit
    assign shifted = {rem, quo[`XLEN-1]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (running) begin
                if (cnt == '0) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (start) begin
                running <= 1'b1;
                cnt     <= CNT_W'(`DIV_STEPS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running) begin
            quo   <= dividend_mag;
            rem   <= '0;
            dvs   <= divisor_mag;
            neg_q <= is_signed && (dividend[`XLEN-1] ^ divisor[`XLEN-1]);
            neg_r <= is_signed && dividend[`XLEN-1];
        end else if (running && cnt != '0) begin
            // restore when the trial subtraction goes negative
            rem <= trial[`XLEN] ? shifted[`XLEN-1:0] : trial[`XLEN-1:0];
            quo <= {quo[`XLEN-2:0], ~trial[`XLEN]};
        end
    end

    // remainder takes the sign of the dividend
    always_ff @(posedge clk) begin
        if (running && cnt == '0) begin
            quotient  <= neg_q ? -quo : quo;
            remainder <= neg_r ? -rem : rem;
        end
    end

endmodule

`default_nettype wire

/* src/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// data path width
`define XLEN 32

// divider steps with one quotient bit each
`define DIV_STEPS `XLEN

`endif

/* src/exec_pkg.sv */
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        FUN_X,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        JALR,
        COPY1,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        DIV,
        DIVU,
        REM,
        REMU
    } exec_fun_t;

    // byte enables of a store
    typedef logic [3:0] mem_wen_t;
    typedef logic [3:0] wb_sel_t;
    typedef logic [2:0] csr_cmd_t;

    typedef logic [`XLEN-1:0] word_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        exec_fun_t fun;
        word_t     op1;
        word_t     op2;
        word_t     rs2;
        word_t     imm_i;
        word_t     imm_b;
        mem_wen_t  mem_wen;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        logic [4:0] wb_addr;
        csr_cmd_t  csr_cmd;
        logic      jmp;
    } ex_in_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_out;
        logic      br_taken;
        word_t     br_target;
        word_t     pc;
        word_t     op1;
        word_t     rs2;
        word_t     imm_i;
        mem_wen_t  mem_wen;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        logic [4:0] wb_addr;
        csr_cmd_t  csr_cmd;
        logic      jmp;
    } ex_out_t;

    typedef struct packed {
        word_t alu_out;
        logic  br_taken;
        word_t br_target;
    } alu_res_t;

    function automatic logic is_div_fun(input exec_fun_t fun);
        return fun inside {DIV, DIVU, REM, REMU};
    endfunction

endpackage

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_in,
    input  logic              flush,
    input  exec_pkg::ex_in_t  in,
    output exec_pkg::ex_out_t out,
    output logic              busy
);
    import exec_pkg::*;

    ex_in_t           saved;
    ex_in_t           cur;
    alu_res_t         alu_res;
    ex_out_t          next_out;
    logic             div_op;
    logic             div_rem;
    logic             div_signed;
    logic             div_start;
    logic             div_done;
    logic             hold_div;
    logic             hold_out;
    logic [`XLEN-1:0] div_quo;
    logic [`XLEN-1:0] div_remainder;
    logic [`XLEN-1:0] div_value;

    // replay copy while stalled or while a divide runs
    assign cur = (stall_in || busy) ? saved : in;

    assign div_op     = cur.valid && is_div_fun(cur.fun);
    assign div_rem    = cur.fun inside {REM, REMU};
    assign div_signed = cur.fun inside {DIV, REM};

    // a finished divide replayed under stall keeps its result
    assign hold_out  = stall_in && hold_div && !flush;
    assign div_start = div_op && cur.op2 != '0 && !busy && !hold_out && !flush;

    alu_branch alu_branch_i (
        .fun   (cur.fun),
        .op1   (cur.op1),
        .op2   (cur.op2),
        .pc    (cur.pc),
        .imm_b (cur.imm_b),
        .res   (alu_res)
    );

    div_unit div_unit_i (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .is_signed (div_signed),
        .abort     (flush),
        .dividend  (cur.op1),
        .divisor   (cur.op2),
        .done      (div_done),
        .quotient  (div_quo),
        .remainder (div_remainder)
    );

    // zero divisor resolves here without the divider
    always_comb begin
        if (div_done) begin
            div_value = div_rem ? div_remainder : div_quo;
        end else begin
            div_value = div_rem ? cur.op1 : '1;
        end
    end

    always_comb begin
        next_out.valid     = cur.valid;
        next_out.alu_out   = is_div_fun(cur.fun) ? div_value : alu_res.alu_out;
        next_out.br_taken  = alu_res.br_taken;
        next_out.br_target = alu_res.br_target;
        next_out.pc        = cur.pc;
        next_out.op1       = cur.op1;
        next_out.rs2       = cur.rs2;
        next_out.imm_i     = cur.imm_i;
        next_out.mem_wen   = cur.mem_wen;
        next_out.rf_wen    = cur.rf_wen;
        next_out.wb_sel    = cur.wb_sel;
        next_out.wb_addr   = cur.wb_addr;
        next_out.csr_cmd   = cur.csr_cmd;
        next_out.jmp       = cur.jmp;

        // nothing valid until the quotient is back
        if (div_start || (busy && !div_done)) begin
            next_out.valid = 1'b0;
        end

        if (flush) begin
            next_out.valid    = 1'b0;
            next_out.br_taken = 1'b0;
            next_out.rf_wen   = 1'b0;
            next_out.mem_wen  = '0;
            next_out.jmp      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid    <= 1'b0;
            out.br_taken <= 1'b0;
            out.rf_wen   <= 1'b0;
            out.mem_wen  <= '0;
            out.jmp      <= 1'b0;
        end else if (!hold_out) begin
            out <= next_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy     <= 1'b0;
            hold_div <= 1'b0;
        end else begin
            if (div_start) begin
                busy <= 1'b1;
            end else if (div_done) begin
                busy <= 1'b0;
            end

            if (div_done) begin
                hold_div <= 1'b1;
            end else if (!stall_in) begin
                hold_div <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            saved.valid <= 1'b0;
            saved.fun   <= FUN_X;
        end else begin
            saved <= cur;
            // killed instruction becomes a bubble
            if (flush) begin
                saved.valid <= 1'b0;
                saved.fun   <= FUN_X;
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
+incdir+verification
src/exec_pkg.sv
src/alu_branch.sv
src/div_unit.sv
src/execute_stage.sv
verification/tb_execute_stage.sv

/* verification/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

// operands leaning toward 0, -1 and the most negative value
function automatic logic [`XLEN-1:0] rand_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
        3'd0: return '0;
        3'd1: return '1;
        3'd2: return {1'b1, {(`XLEN-1){1'b0}}};
        3'd3: return `XLEN'(r[10:3]);
        default: return `XLEN'(next_rand());
    endcase
endfunction

function automatic logic [`XLEN-1:0] div_model(input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b,
                                               input logic sgn,
                                               input logic want_rem);
    logic [`XLEN-1:0] min_val;
    min_val = {1'b1, {(`XLEN-1){1'b0}}};
    if (b == '0) begin
        return want_rem ? a : '1;
    end
    if (sgn && a == min_val && b == '1) begin
        return want_rem ? '0 : min_val;
    end
    if (sgn) begin
        return want_rem ? $unsigned($signed(a) % $signed(b))
                        : $unsigned($signed(a) / $signed(b));
    end
    return want_rem ? a % b : a / b;
endfunction

// expected stage output for one instruction
function automatic ex_out_t model_out(input ex_in_t x);
    ex_out_t o;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [4:0] sh;
    a = x.op1;
    b = x.op2;
    sh = b[4:0];
    o = '0;
    o.valid = x.valid;
    o.br_target = x.pc + x.imm_b;
    case (x.fun)
        ADD:   o.alu_out = a + b;
        SUB:   o.alu_out = a - b;
        AND:   o.alu_out = a & b;
        OR:    o.alu_out = a | b;
        XOR:   o.alu_out = a ^ b;
        SLL:   o.alu_out = a << sh;
        SRL:   o.alu_out = a >> sh;
        SRA:   o.alu_out = (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
        SLT:   o.alu_out = ($signed(a) < $signed(b)) ? 1 : 0;
        SLTU:  o.alu_out = (a < b) ? 1 : 0;
        JALR:  o.alu_out = (a + b) & ~`XLEN'(1);
        COPY1: o.alu_out = a;
        BEQ:   o.br_taken = a == b;
        BNE:   o.br_taken = a != b;
        BLT:   o.br_taken = $signed(a) < $signed(b);
        BGE:   o.br_taken = $signed(a) >= $signed(b);
        BLTU:  o.br_taken = a < b;
        BGEU:  o.br_taken = a >= b;
        DIV:   o.alu_out = div_model(a, b, 1'b1, 1'b0);
        DIVU:  o.alu_out = div_model(a, b, 1'b0, 1'b0);
        REM:   o.alu_out = div_model(a, b, 1'b1, 1'b1);
        REMU:  o.alu_out = div_model(a, b, 1'b0, 1'b1);
        default: o.alu_out = '0;
    endcase
    o.pc = x.pc;
    o.op1 = x.op1;
    o.rs2 = x.rs2;
    o.imm_i = x.imm_i;
    o.mem_wen = x.mem_wen;
    o.rf_wen = x.rf_wen;
    o.wb_sel = x.wb_sel;
    o.wb_addr = x.wb_addr;
    o.csr_cmd = x.csr_cmd;
    o.jmp = x.jmp;
    return o;
endfunction

`endif

/* verification/tb_execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module tb_execute_stage;
    import exec_pkg::*;

    localparam int N_ALU = 200;
    localparam int N_BR = 60;
    localparam int N_DIV = 60;
    localparam int N_STALL = 30;
    localparam int N_FLUSH = 30;
    localparam int N_OPS = N_ALU + N_BR + N_DIV + N_STALL + 2 * N_FLUSH;
    localparam int CYCLE_LIMIT = N_OPS * (`DIV_STEPS + 4) + 1000;

    logic clk = 1'b0;
    logic rst;
    logic stall_in;
    logic flush;
    ex_in_t in;
    ex_out_t out;
    logic busy;
    logic [31:0] rng_state = 32'h59ba;
    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    `include "exec_model.svh"

    execute_stage execute_stage_i (
        .clk      (clk),
        .rst      (rst),
        .stall_in (stall_in),
        .flush    (flush),
        .in       (in),
        .out      (out),
        .busy     (busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_out(input string name, input ex_out_t exp, input ex_out_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_busy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s busy expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // killed output carries no side effects
    task automatic check_kill(input string name, input ex_out_t act);
        if (act.valid !== 1'b0 || act.br_taken !== 1'b0 || act.rf_wen !== 1'b0 ||
            act.mem_wen !== 4'b0 || act.jmp !== 1'b0) begin
            $display("%s: flushed output still has control bits set", name);
            errors++;
        end
    endtask

    function automatic ex_in_t rand_in(input exec_fun_t fun);
        ex_in_t r;
        logic [31:0] t;
        r = '0;
        r.valid = 1'b1;
        r.fun = fun;
        r.pc = next_rand() & 32'hffff_fffc;
        r.op1 = rand_operand();
        r.op2 = rand_operand();
        r.rs2 = next_rand();
        r.imm_i = next_rand();
        r.imm_b = next_rand();
        t = next_rand();
        r.mem_wen = mem_wen_t'(t[3:0]);
        r.rf_wen = t[4];
        r.wb_sel = wb_sel_t'(t[8:5]);
        r.wb_addr = t[13:9];
        r.csr_cmd = csr_cmd_t'(t[16:14]);
        r.jmp = t[17];
        return r;
    endfunction

    function automatic exec_fun_t rand_alu_fun();
        return exec_fun_t'(5'(next_rand() % 19));
    endfunction

    task automatic run_op(input string name, input ex_in_t x);
        ex_out_t exp;
        logic long_div;
        int waited;
        exp = model_out(x);
        long_div = is_div_fun(x.fun) && x.op2 != '0;
        waited = 0;
        @(posedge clk);
        in <= x;
        @(posedge clk);
        in <= '0;
        @(negedge clk);
        while (out.valid !== 1'b1 && long_div && waited < `DIV_STEPS + 8) begin
            check_busy(name, 1'b1, busy);
            @(negedge clk);
            waited++;
        end
        if (out.valid !== 1'b1) begin
            $display("%s: no valid output appeared", name);
            errors++;
        end else begin
            check_out(name, exp, out);
            check_busy(name, 1'b0, busy);
        end
        @(negedge clk);
        if (out.valid !== 1'b0) begin
            $display("%s: more than one valid output for one instruction", name);
            errors++;
        end
    endtask

    task automatic run_stall(input string name, input ex_in_t x, input int span);
        ex_out_t exp;
        exp = model_out(x);
        @(posedge clk);
        in <= x;
        @(posedge clk);
        in <= rand_in(rand_alu_fun());
        stall_in <= 1'b1;
        for (int i = 0; i < span; i++) begin
            @(negedge clk);
            check_out(name, exp, out);
            @(posedge clk);
            if (i == span - 1) begin
                stall_in <= 1'b0;
                in <= '0;
            end else begin
                in <= rand_in(rand_alu_fun());
            end
        end
        // last replayed cycle
        @(negedge clk);
        check_out(name, exp, out);
    endtask

    task automatic run_flush(input string name, input ex_in_t x, input int delay);
        @(posedge clk);
        in <= x;
        if (!is_div_fun(x.fun)) begin
            flush <= 1'b1;
        end else begin
            @(posedge clk);
            in <= '0;
            repeat (delay) @(posedge clk);
            flush <= 1'b1;
        end
        @(posedge clk);
        flush <= 1'b0;
        in <= '0;
        @(negedge clk);
        check_kill(name, out);
        check_busy(name, 1'b0, busy);
        run_op({name, "_next"}, rand_in(rand_alu_fun()));
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s ok", name);
        end else begin
            tests_bad++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e;
        ex_in_t x;
        rst = 1'b1;
        stall_in = 1'b0;
        flush = 1'b0;
        in = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        e = errors;
        repeat (6) begin
            @(negedge clk);
            check_busy("reset_idle", 1'b0, busy);
            if (out.valid !== 1'b0) begin
                $display("reset_idle: valid output with no stimulus");
                errors++;
            end
        end
        end_test("reset_idle", e);

        e = errors;
        for (int i = 0; i < N_ALU; i++) begin
            run_op("alu", rand_in(rand_alu_fun()));
        end
        end_test("alu", e);

        e = errors;
        for (int i = 0; i < N_BR; i++) begin
            x = rand_in(exec_fun_t'(5'(13 + next_rand() % 6)));
            case (i % 4)
                0: x.op2 = x.op1;
                1: begin
                    x.op1 = 32'h7fff_ffff;
                    x.op2 = 32'h8000_0000;
                end
                2: begin
                    x.op1 = 32'hffff_ffff;
                    x.op2 = 32'h0000_0000;
                end
                default: ;
            endcase
            if (i % 8 >= 4) begin
                {x.op1, x.op2} = {x.op2, x.op1};
            end
            run_op("branch", x);
        end
        end_test("branch", e);

        e = errors;
        for (int i = 0; i < N_DIV; i++) begin
            x = rand_in(exec_fun_t'(5'(19 + next_rand() % 4)));
            if (i % 10 == 0) begin
                x.op2 = '0;
            end else if (i % 10 == 1) begin
                x.op1 = 32'h8000_0000;
                x.op2 = 32'hffff_ffff;
            end
            run_op("divide", x);
        end
        end_test("divide", e);

        e = errors;
        for (int i = 0; i < N_STALL; i++) begin
            run_stall("stall", rand_in(rand_alu_fun()), 1 + int'(next_rand() % 8));
        end
        end_test("stall", e);

        e = errors;
        for (int i = 0; i < N_FLUSH; i++) begin
            if (i % 2 == 0) begin
                x = rand_in(exec_fun_t'(5'(19 + next_rand() % 4)));
                x.op2 = x.op2 | 32'h1;
            end else begin
                x = rand_in(rand_alu_fun());
            end
            run_flush("flush", x, int'(next_rand() % `DIV_STEPS));
        end
        end_test("flush", e);

        $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
